//--- include/audio_cfg.svh
// ####################
// build options and register offsets
// for the audio output block
// ####################
`ifndef AUDIO_CFG_SVH
`define AUDIO_CFG_SVH

// fifo holds 2**AW stereo samples
`define AUDIO_FIFO_AW 4

// clk cycles per bit clock half period
`define AUDIO_BCLK_DIV 2

// wishbone register offsets
`define AUDIO_ADR_CTRL0      16'h0000
`define AUDIO_ADR_STAT0      16'h0004
`define AUDIO_ADR_FIFO_LOW   16'h0008
`define AUDIO_ADR_FIFO_LEVEL 16'h000C
`define AUDIO_ADR_LEFT       16'h0010
`define AUDIO_ADR_RIGHT      16'h0014

`endif

//--- sources.f
+incdir+include
src/audio_pkg.sv
src/audio_fifo_if.sv
src/audio_regfile.sv
src/sample_fifo.sv
src/i2s_framer.sv
src/sd_dac.sv
src/audio_top.sv
tb/tb_audio_top.sv

//--- src/audio_fifo_if.sv
// ####################
// push side and status between register file and sample fifo
// ####################
`timescale 1ns/1ps
`default_nettype none

interface audio_fifo_if import audio_pkg::*; ();

    // push side, driven by the register file
    logic    push;
    stereo_t push_data;
    level_t  threshold;

    // status, driven by the fifo
    level_t  level;
    logic    empty;
    logic    full;
    logic    low;

    modport regs (
        output push,
        output push_data,
        output threshold,
        input  level,
        input  empty,
        input  full,
        input  low
    );

    modport fifo (
        input  push,
        input  push_data,
        input  threshold,
        output level,
        output empty,
        output full,
        output low
    );

endinterface

`default_nettype wire

//--- src/audio_pkg.sv
// ####################
// sample, stereo and fifo level types
// plus control and status bit positions
// ####################
`default_nettype none

`include "audio_cfg.svh"

package audio_pkg;

    // signed two's complement audio sample
    typedef logic signed [23:0] sample_t;

    // left sits in the low half, right in the high half
    typedef struct packed {
        sample_t right;
        sample_t left;
    } stereo_t;

    // one bit wider than the fifo address so full is representable
    typedef logic [`AUDIO_FIFO_AW:0] level_t;

    // CTRL0 bits
    localparam int CTRL_RST_BIT      = 0;
    localparam int CTRL_DAC_MODE_BIT = 1;
    localparam int CTRL_DAC_EN_BIT   = 2;
    localparam int CTRL_I2S_EN_BIT   = 3;

    // STAT0 bits
    localparam int STAT_LOW_BIT   = 0;
    localparam int STAT_EMPTY_BIT = 1;
    localparam int STAT_FULL_BIT  = 2;

endpackage

`default_nettype wire

//--- src/audio_regfile.sv
// ####################
// wishbone register file for the audio block
// control bits, fifo threshold and sample commit
// ####################
`timescale 1ns/1ps
`default_nettype none

`include "audio_cfg.svh"

module audio_regfile import audio_pkg::*; (
    input  wire logic        clk,
    input  wire logic        rst,

    // wishbone classic slave
    input  wire logic [15:0] wb_adr_i,
    input  wire logic [31:0] wb_dat_i,
    input  wire logic [3:0]  wb_sel_i,
    input  wire logic        wb_stb_i,
    input  wire logic        wb_we_i,
    output logic      [31:0] wb_dat_o,
    output logic             wb_ack_o,

    audio_fifo_if.regs       fifo,

    output logic             soft_rst_o,
    output logic             run_o,
    output logic             i2s_out_en_o,
    output logic             dac_en_o
);

    logic [3:0]  ctrl_q;
    level_t      thr_q;
    stereo_t     sample_q;
    logic        push_q;
    logic [31:0] low_merged;
    logic        wr_stb;
    logic        rd_stb;
    logic        commit;

    assign wr_stb = wb_stb_i && wb_we_i;
    assign rd_stb = wb_stb_i && !wb_we_i;

    // bit 31 commits only when its byte lane is selected
    assign commit = wr_stb && wb_sel_i[3] && wb_dat_i[31] &&
        (wb_adr_i == `AUDIO_ADR_LEFT || wb_adr_i == `AUDIO_ADR_RIGHT);

    // byte lane merge for the threshold register
    always_comb begin
        low_merged = 32'(thr_q);
        for (int b = 0; b < 4; b++) begin
            if (wb_sel_i[b]) begin
                low_merged[8*b +: 8] = wb_dat_i[8*b +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ctrl_q <= '0;
            thr_q  <= '0;
            push_q <= 1'b0;
        end else begin
            // one cycle strobe after the committing write
            push_q <= commit;
            if (wr_stb && wb_adr_i == `AUDIO_ADR_CTRL0 && wb_sel_i[0]) begin
                ctrl_q <= wb_dat_i[3:0];
            end
            if (wr_stb && wb_adr_i == `AUDIO_ADR_FIFO_LOW) begin
                thr_q <= level_t'(low_merged);
            end
        end
    end

    // sample assembly, left in 23:0 and right in 47:24
    always_ff @(posedge clk) begin
        for (int b = 0; b < 3; b++) begin
            if (wr_stb && wb_sel_i[b]) begin
                if (wb_adr_i == `AUDIO_ADR_LEFT) begin
                    sample_q[8*b +: 8] <= wb_dat_i[8*b +: 8];
                end
                if (wb_adr_i == `AUDIO_ADR_RIGHT) begin
                    sample_q[24 + 8*b +: 8] <= wb_dat_i[8*b +: 8];
                end
            end
        end
    end

    // registered read data and ack, zero outside read acks
    always_ff @(posedge clk) begin
        if (rst) begin
            wb_ack_o <= 1'b0;
            wb_dat_o <= '0;
        end else begin
            wb_ack_o <= wb_stb_i;
            wb_dat_o <= '0;
            if (rd_stb) begin
                case (wb_adr_i)
                    `AUDIO_ADR_CTRL0: wb_dat_o <= 32'(ctrl_q);
                    `AUDIO_ADR_STAT0: begin
                        wb_dat_o[STAT_LOW_BIT]   <= fifo.low;
                        wb_dat_o[STAT_EMPTY_BIT] <= fifo.empty;
                        wb_dat_o[STAT_FULL_BIT]  <= fifo.full;
                    end
                    `AUDIO_ADR_FIFO_LOW:   wb_dat_o <= 32'(thr_q);
                    `AUDIO_ADR_FIFO_LEVEL: wb_dat_o <= 32'(fifo.level);
                    default:               wb_dat_o <= '0;
                endcase
            end
        end
    end

    assign fifo.push      = push_q;
    assign fifo.push_data = sample_q;
    assign fifo.threshold = thr_q;

    assign soft_rst_o = ctrl_q[CTRL_RST_BIT];
    // framer runs for either output path
    assign run_o = ctrl_q[CTRL_I2S_EN_BIT] || ctrl_q[CTRL_DAC_EN_BIT];
    assign i2s_out_en_o = ctrl_q[CTRL_I2S_EN_BIT] && !ctrl_q[CTRL_DAC_MODE_BIT];
    assign dac_en_o = ctrl_q[CTRL_DAC_EN_BIT] && ctrl_q[CTRL_DAC_MODE_BIT];

endmodule

`default_nettype wire

//--- src/audio_top.sv
// ####################
// audio output block top level
// ####################
`timescale 1ns/1ps
`default_nettype none

module audio_top import audio_pkg::*; (
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire logic [15:0] wb_adr_i,
    input  wire logic [31:0] wb_dat_i,
    input  wire logic [3:0]  wb_sel_i,
    input  wire logic        wb_stb_i,
    input  wire logic        wb_we_i,
    output logic      [31:0] wb_dat_o,
    output logic             wb_ack_o,
    output logic             i2s_bclk_o,
    output logic             i2s_ws_o,
    output logic             i2s_sd_o,
    output logic             dac_left_o,
    output logic             dac_right_o
);

    logic    soft_rst;
    logic    run;
    logic    i2s_out_en;
    logic    dac_en;
    logic    pop;
    stereo_t pop_data;
    logic    empty;
    stereo_t frame_sample;
    logic    bit_tick;

    audio_fifo_if u_fifo_if ();

    audio_regfile u_regfile (
        .clk          (clk),
        .rst          (rst),
        .wb_adr_i     (wb_adr_i),
        .wb_dat_i     (wb_dat_i),
        .wb_sel_i     (wb_sel_i),
        .wb_stb_i     (wb_stb_i),
        .wb_we_i      (wb_we_i),
        .wb_dat_o     (wb_dat_o),
        .wb_ack_o     (wb_ack_o),
        .fifo         (u_fifo_if.regs),
        .soft_rst_o   (soft_rst),
        .run_o        (run),
        .i2s_out_en_o (i2s_out_en),
        .dac_en_o     (dac_en)
    );

    sample_fifo u_fifo (
        .clk        (clk),
        .rst        (rst),
        .soft_rst_i (soft_rst),
        .q          (u_fifo_if.fifo),
        .pop_i      (pop),
        .pop_data_o (pop_data),
        .empty_o    (empty)
    );

    i2s_framer u_framer (
        .clk            (clk),
        .rst            (rst),
        .soft_rst_i     (soft_rst),
        .run_i          (run),
        .i2s_out_en_i   (i2s_out_en),
        .pop_o          (pop),
        .pop_data_i     (pop_data),
        .empty_i        (empty),
        .frame_sample_o (frame_sample),
        .bit_tick_o     (bit_tick),
        .i2s_bclk_o     (i2s_bclk_o),
        .i2s_ws_o       (i2s_ws_o),
        .i2s_sd_o       (i2s_sd_o)
    );

    sd_dac u_dac (
        .clk            (clk),
        .rst            (rst),
        .soft_rst_i     (soft_rst),
        .dac_en_i       (dac_en),
        .bit_tick_i     (bit_tick),
        .frame_sample_i (frame_sample),
        .dac_left_o     (dac_left_o),
        .dac_right_o    (dac_right_o)
    );

endmodule

`default_nettype wire

//--- src/i2s_framer.sv
// ####################
// i2s frame generator, bit clock and word select
// pops one stereo sample per 48 bit frame
// ####################
`timescale 1ns/1ps
`default_nettype none

`include "audio_cfg.svh"

module i2s_framer import audio_pkg::*; (
    input  wire logic     clk,
    input  wire logic     rst,
    input  wire logic     soft_rst_i,
    input  wire logic     run_i,
    input  wire logic     i2s_out_en_i,
    output logic          pop_o,
    input  wire stereo_t  pop_data_i,
    input  wire logic     empty_i,
    output stereo_t       frame_sample_o,
    output logic          bit_tick_o,
    output logic          i2s_bclk_o,
    output logic          i2s_ws_o,
    output logic          i2s_sd_o
);

    localparam int DIV   = `AUDIO_BCLK_DIV;
    localparam int DIV_W = (DIV > 1) ? $clog2(DIV) : 1;
    localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(DIV - 1);

    logic             clear;
    logic             active;
    logic             ticking;
    logic [DIV_W-1:0] div_cnt;
    logic             bclk_q;
    logic [5:0]       bit_cnt;
    logic [5:0]       bit_nxt;
    logic             ws_q;
    logic             sd_q;
    logic [47:0]      sr;
    stereo_t          frame_q;
    stereo_t          loaded;
    logic             rise_evt;
    logic             fall_evt;
    logic             start_evt;

    assign clear    = rst || soft_rst_i || !run_i;
    assign ticking  = active && !clear;
    assign rise_evt = ticking && (div_cnt == DIV_LAST) && !bclk_q;
    assign fall_evt = ticking && (div_cnt == DIV_LAST) && bclk_q;
    assign bit_nxt  = (bit_cnt == 6'd47) ? 6'd0 : bit_cnt + 6'd1;

    // first run cycle acts as the opening falling edge
    assign start_evt = !clear && (!active || (fall_evt && bit_cnt == 6'd47));
    assign loaded    = empty_i ? stereo_t'('0) : pop_data_i;

    always_ff @(posedge clk) begin
        if (clear) begin
            active  <= 1'b0;
            div_cnt <= '0;
            bclk_q  <= 1'b0;
            bit_cnt <= '0;
            ws_q    <= 1'b0;
            sd_q    <= 1'b0;
        end else begin
            active <= 1'b1;
            if (active) begin
                if (div_cnt == DIV_LAST) begin
                    div_cnt <= '0;
                    bclk_q  <= !bclk_q;
                end else begin
                    div_cnt <= div_cnt + 1'b1;
                end
                // ws leads the msb by one bit clock
                if (fall_evt) begin
                    bit_cnt <= bit_nxt;
                    ws_q    <= (bit_nxt >= 6'd24);
                    sd_q    <= sr[47];
                end
            end
        end
    end

    // shift register is sent left first, msb first
    always_ff @(posedge clk) begin
        if (start_evt) begin
            sr      <= {loaded.left, loaded.right};
            frame_q <= loaded;
        end else if (fall_evt) begin
            sr <= {sr[46:0], 1'b0};
        end
    end

    assign pop_o          = start_evt;
    assign frame_sample_o = frame_q;
    assign bit_tick_o     = rise_evt;

    // pins held low when the dac path owns the samples
    assign i2s_bclk_o = bclk_q && i2s_out_en_i;
    assign i2s_ws_o   = ws_q && i2s_out_en_i;
    assign i2s_sd_o   = sd_q && i2s_out_en_i;

endmodule

`default_nettype wire

//--- src/sample_fifo.sv
// ####################
// stereo sample fifo with level and threshold status
// ####################
`timescale 1ns/1ps
`default_nettype none

`include "audio_cfg.svh"

module sample_fifo import audio_pkg::*; (
    input  wire logic  clk,
    input  wire logic  rst,
    input  wire logic  soft_rst_i,
    audio_fifo_if.fifo q,
    input  wire logic  pop_i,
    output stereo_t    pop_data_o,
    output logic       empty_o
);

    localparam int AW    = `AUDIO_FIFO_AW;
    localparam int DEPTH = 1 << AW;

    stereo_t     mem [DEPTH];
    logic [AW:0] wr_ptr;
    logic [AW:0] rd_ptr;
    level_t      level;
    logic        full;
    logic        empty;
    logic        do_push;
    logic        do_pop;

    // pointers carry a wrap bit above the address
    assign level = wr_ptr - rd_ptr;
    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

    // push on full and pop on empty are ignored
    assign do_push = q.push && !full;
    assign do_pop  = pop_i && !empty;

    always_ff @(posedge clk) begin
        if (rst || soft_rst_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr[AW-1:0]] <= q.push_data;
        end
    end

    // head entry is visible without a read cycle
    assign pop_data_o = mem[rd_ptr[AW-1:0]];
    assign empty_o    = empty;

    assign q.level = level;
    assign q.empty = empty;
    assign q.full  = full;
    assign q.low   = (level < q.threshold);

endmodule

`default_nettype wire

//--- src/sd_dac.sv
// ####################
// first order sigma-delta dac, one per channel
// ####################
`timescale 1ns/1ps
`default_nettype none

module sd_dac import audio_pkg::*; (
    input  wire logic    clk,
    input  wire logic    rst,
    input  wire logic    soft_rst_i,
    input  wire logic    dac_en_i,
    input  wire logic    bit_tick_i,
    input  wire stereo_t frame_sample_i,
    output logic         dac_left_o,
    output logic         dac_right_o
);

    sample_t     chan [2];
    logic [23:0] acc  [2];
    logic [24:0] sum  [2];
    logic [1:0]  bit_q;

    assign chan[0] = frame_sample_i.left;
    assign chan[1] = frame_sample_i.right;

    // offset binary is the sample with its sign bit flipped
    always_comb begin
        for (int ch = 0; ch < 2; ch++) begin
            sum[ch] = {1'b0, acc[ch]} + {1'b0, ~chan[ch][23], chan[ch][22:0]};
        end
    end

    always_ff @(posedge clk) begin
        if (rst || soft_rst_i || !dac_en_i) begin
            acc[0] <= '0;
            acc[1] <= '0;
            bit_q  <= '0;
        end else if (bit_tick_i) begin
            // carry out is the density bit, held until the next tick
            for (int ch = 0; ch < 2; ch++) begin
                acc[ch]   <= sum[ch][23:0];
                bit_q[ch] <= sum[ch][24];
            end
        end
    end

    assign dac_left_o  = bit_q[0];
    assign dac_right_o = bit_q[1];

endmodule

`default_nettype wire

//--- tb/tb_audio_top.sv
// ####################
// testbench for the audio output block
// wishbone stimulus, fifo model, i2s and dac capture
// ####################
`timescale 1ns/1ps
`default_nettype none

`include "audio_cfg.svh"

module tb_audio_top import audio_pkg::*; ();

    localparam int DIV       = `AUDIO_BCLK_DIV;
    localparam int DEPTH     = 1 << `AUDIO_FIFO_AW;
    localparam int FRAME_CLK = 48 * 2 * DIV;
    localparam int N_OPS     = 400;
    localparam int N_FRAMES  = 30;
    localparam int LIMIT     = N_OPS * 10 + N_FRAMES * 48 * 2 * DIV * 2;
    localparam int ZERO_FRAMES = 3;
    localparam int DAC_TICKS   = 3 * 48;

    logic        clk;
    logic        rst;
    logic [15:0] wb_adr;
    logic [31:0] wb_dat_w;
    logic [3:0]  wb_sel;
    logic        wb_stb;
    logic        wb_we;
    logic [31:0] wb_dat_r;
    logic        wb_ack;
    logic        bclk;
    logic        ws;
    logic        sd;
    logic        dac_l;
    logic        dac_r;

    // register and fifo model
    logic [3:0]  ctrl_m;
    level_t      thr_m;
    stereo_t     asm_m;
    stereo_t     fifo_m [$];
    stereo_t     sent_m [$];

    // capture state
    stereo_t     frames_rx [$];
    stereo_t     rx_frame;
    sample_t     left_rx;
    logic [23:0] word_sh;
    logic        bclk_prev;
    logic        ws_prev;
    int          bclk_rises;
    logic        tick_pend;
    logic        dac_count_en;
    logic        i2s_phase;
    logic        dac_phase;
    int          dac_ticks;
    int          ones_l;
    int          ones_r;

    int          err_bus;
    int          err_reg;
    int          err_fifo;
    int          err_i2s;
    int          err_dac;

    audio_top u_dut (
        .clk         (clk),
        .rst         (rst),
        .wb_adr_i    (wb_adr),
        .wb_dat_i    (wb_dat_w),
        .wb_sel_i    (wb_sel),
        .wb_stb_i    (wb_stb),
        .wb_we_i     (wb_we),
        .wb_dat_o    (wb_dat_r),
        .wb_ack_o    (wb_ack),
        .i2s_bclk_o  (bclk),
        .i2s_ws_o    (ws),
        .i2s_sd_o    (sd),
        .dac_left_o  (dac_l),
        .dac_right_o (dac_r)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        repeat (LIMIT) @(posedge clk);
        $display("timeout: run did not finish within %0d clock cycles", LIMIT);
        $display("Test failures found");
        $finish;
    end

    // i2s receiver, a ws change marks the lsb of the previous word
    always @(negedge clk) begin
        if (bclk && !bclk_prev) begin
            bclk_rises++;
            if (ws != ws_prev) begin
                if (ws_prev) begin
                    rx_frame.left  = left_rx;
                    rx_frame.right = {word_sh[22:0], sd};
                    frames_rx.push_back(rx_frame);
                end else begin
                    left_rx = {word_sh[22:0], sd};
                end
                word_sh = '0;
            end else begin
                word_sh = {word_sh[22:0], sd};
            end
            ws_prev = ws;
        end
        bclk_prev = bclk;
    end

    // dac capture, one sample per bit tick once the output has stepped
    always @(negedge clk) begin
        if (tick_pend && dac_ticks < DAC_TICKS) begin
            dac_ticks++;
            ones_l += dac_l;
            ones_r += dac_r;
        end
        tick_pend = dac_count_en && u_dut.bit_tick;
        if (i2s_phase && (dac_l || dac_r)) begin
            $display("[ERROR] %0t: dac output active while i2s is selected", $time);
            err_dac++;
        end
        if (dac_phase && (bclk || ws || sd)) begin
            $display("[ERROR] %0t: i2s pin active while the dac is selected", $time);
            err_i2s++;
        end
    end

    task automatic wb_cycle(input logic [15:0] adr, input logic [31:0] dat,
                            input logic [3:0] sel, input logic we,
                            output logic [31:0] rdat);
        int n;
        wb_adr   = adr;
        wb_dat_w = dat;
        wb_sel   = sel;
        wb_we    = we;
        wb_stb   = 1'b1;
        @(posedge clk);
        #1;
        wb_stb = 1'b0;
        n = 0;
        while (wb_ack !== 1'b1 && n < 8) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (wb_ack !== 1'b1) begin
            $display("bus access to %h was never acknowledged", adr);
            err_bus++;
        end
        rdat = wb_dat_r;
    endtask

    task automatic reg_write(input logic [15:0] adr, input logic [31:0] dat,
                             input logic [3:0] sel);
        logic [31:0] unused;
        int          base;
        wb_cycle(adr, dat, sel, 1'b1, unused);
        if (adr == `AUDIO_ADR_CTRL0 && sel[0]) begin
            ctrl_m = dat[3:0];
        end
        if (adr == `AUDIO_ADR_FIFO_LOW && sel[0]) begin
            thr_m = level_t'(dat[7:0]);
        end
        if (adr == `AUDIO_ADR_LEFT || adr == `AUDIO_ADR_RIGHT) begin
            base = (adr == `AUDIO_ADR_RIGHT) ? 24 : 0;
            for (int b = 0; b < 3; b++) begin
                if (sel[b]) begin
                    asm_m[base + 8*b +: 8] = dat[8*b +: 8];
                end
            end
            // commit is dropped on a full or flushed fifo
            if (sel[3] && dat[31] && !ctrl_m[0] && fifo_m.size() < DEPTH) begin
                fifo_m.push_back(asm_m);
            end
        end
        if (ctrl_m[0]) begin
            fifo_m.delete();
        end
        // level follows a push one cycle after the ack
        @(posedge clk);
        #1;
    endtask

    task automatic expect_read(input logic [15:0] adr, input logic [31:0] exp,
                               inout int errs);
        logic [31:0] got;
        wb_cycle(adr, 32'h0, 4'hf, 1'b0, got);
        if (got !== exp) begin
            $display("[ERROR] %0t: read of %h returned %h, expected %h", $time, adr, got, exp);
            errs++;
        end
    endtask

    function automatic logic [31:0] stat_model();
        logic [31:0] s;
        s = '0;
        s[STAT_LOW_BIT]   = (fifo_m.size() < thr_m);
        s[STAT_EMPTY_BIT] = (fifo_m.size() == 0);
        s[STAT_FULL_BIT]  = (fifo_m.size() == DEPTH);
        return s;
    endfunction

    task automatic check_status();
        expect_read(`AUDIO_ADR_FIFO_LEVEL, 32'(fifo_m.size()), err_fifo);
        expect_read(`AUDIO_ADR_STAT0, stat_model(), err_fifo);
    endtask

    // carries of a 24 bit accumulator fed with offset binary samples
    function automatic int dac_ones(input sample_t s, input int n_hold, input int n_total);
        logic [23:0] acc;
        logic [23:0] off;
        logic [24:0] sum;
        int          ones;
        acc  = '0;
        ones = 0;
        for (int t = 0; t < n_total; t++) begin
            off  = (t < n_hold) ? 24'(s + 24'h800000) : 24'h800000;
            sum  = {1'b0, acc} + {1'b0, off};
            acc  = sum[23:0];
            ones = ones + sum[24];
        end
        return ones;
    endfunction

    initial begin
        int          n;
        int          exp_frames;
        int          rises_before;
        int          exp_l;
        int          exp_r;
        int          total;
        sample_t     dac_s_l;
        sample_t     dac_s_r;
        stereo_t     exp_f;
        logic [31:0] dat;

        void'($urandom(32'hd8420e88));
        rst          = 1'b1;
        wb_adr       = '0;
        wb_dat_w     = '0;
        wb_sel       = '0;
        wb_stb       = 1'b0;
        wb_we        = 1'b0;
        ctrl_m       = '0;
        thr_m        = '0;
        asm_m        = '0;
        bclk_prev    = 1'b0;
        ws_prev      = 1'b0;
        word_sh      = '0;
        left_rx      = '0;
        bclk_rises   = 0;
        tick_pend    = 1'b0;
        dac_count_en = 1'b0;
        i2s_phase    = 1'b0;
        dac_phase    = 1'b0;
        dac_ticks    = 0;
        ones_l       = 0;
        ones_r       = 0;
        err_bus      = 0;
        err_reg      = 0;
        err_fifo     = 0;
        err_i2s      = 0;
        err_dac      = 0;
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;

        // register access, enables stay off
        expect_read(`AUDIO_ADR_CTRL0, 32'h0, err_reg);
        expect_read(`AUDIO_ADR_STAT0, stat_model(), err_reg);
        expect_read(`AUDIO_ADR_FIFO_LOW, 32'h0, err_reg);
        expect_read(`AUDIO_ADR_FIFO_LEVEL, 32'h0, err_reg);
        for (int i = 0; i < 16; i++) begin
            dat = $urandom() & ~(32'h1 << CTRL_DAC_EN_BIT) & ~(32'h1 << CTRL_I2S_EN_BIT);
            reg_write(`AUDIO_ADR_CTRL0, dat, 4'($urandom()));
            expect_read(`AUDIO_ADR_CTRL0, 32'(ctrl_m), err_reg);
            reg_write(`AUDIO_ADR_FIFO_LOW, $urandom(), 4'($urandom()));
            expect_read(`AUDIO_ADR_FIFO_LOW, 32'(thr_m), err_reg);
        end
        expect_read(`AUDIO_ADR_LEFT, 32'h0, err_reg);
        expect_read(`AUDIO_ADR_RIGHT, 32'h0, err_reg);
        for (int i = 0; i < 4; i++) begin
            expect_read(16'(16'h0018 + 4 * $urandom_range(0, 1000)), 32'h0, err_reg);
        end
        reg_write(`AUDIO_ADR_CTRL0, 32'h0, 4'h1);

        // fifo status and sample assembly, framing off
        reg_write(`AUDIO_ADR_FIFO_LOW, $urandom_range(0, DEPTH + 4), 4'h1);
        reg_write(`AUDIO_ADR_LEFT, $urandom() & 32'h00ff_ffff, 4'h7);
        reg_write(`AUDIO_ADR_RIGHT, $urandom() & 32'h00ff_ffff, 4'h7);
        for (int i = 0; i < 20; i++) begin
            reg_write(`AUDIO_ADR_LEFT, $urandom(), 4'($urandom()));
            check_status();
            reg_write(`AUDIO_ADR_RIGHT, $urandom() | 32'h8000_0000, 4'($urandom()) | 4'h8);
            check_status();
            if (i == 10) begin
                reg_write(`AUDIO_ADR_FIFO_LOW, $urandom_range(0, 31), 4'h1);
            end
        end

        // i2s playback of the queued samples, then silence
        sent_m = fifo_m;
        exp_frames = sent_m.size() + ZERO_FRAMES;
        frames_rx.delete();
        i2s_phase = 1'b1;
        reg_write(`AUDIO_ADR_CTRL0, 32'h1 << CTRL_I2S_EN_BIT, 4'h1);
        n = 0;
        while (frames_rx.size() < exp_frames && n < (exp_frames + 2) * FRAME_CLK) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (frames_rx.size() < exp_frames) begin
            $display("i2s capture stopped at %0d of %0d frames", frames_rx.size(), exp_frames);
            err_i2s++;
        end
        reg_write(`AUDIO_ADR_CTRL0, 32'h0, 4'h1);
        i2s_phase = 1'b0;
        fifo_m.delete();
        for (int i = 0; i < exp_frames && i < frames_rx.size(); i++) begin
            exp_f = (i < sent_m.size()) ? sent_m[i] : stereo_t'('0);
            if (frames_rx[i] !== exp_f) begin
                $display("[ERROR] %0t: i2s frame %0d is %h, expected %h",
                         $time, i, frames_rx[i], exp_f);
                err_i2s++;
            end
        end

        // dac mode with one constant sample
        dac_s_l = sample_t'($urandom());
        dac_s_r = sample_t'($urandom());
        reg_write(`AUDIO_ADR_LEFT, {8'h00, dac_s_l}, 4'h7);
        reg_write(`AUDIO_ADR_RIGHT, {8'h80, dac_s_r}, 4'hf);
        check_status();
        rises_before = bclk_rises;
        dac_ticks    = 0;
        ones_l       = 0;
        ones_r       = 0;
        dac_phase    = 1'b1;
        dac_count_en = 1'b1;
        reg_write(`AUDIO_ADR_CTRL0, (32'h1 << CTRL_DAC_MODE_BIT) | (32'h1 << CTRL_DAC_EN_BIT),
                  4'h1);
        n = 0;
        while (dac_ticks < DAC_TICKS && n < (DAC_TICKS + 8) * 2 * DIV) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (dac_ticks < DAC_TICKS) begin
            $display("dac produced only %0d of %0d bit ticks", dac_ticks, DAC_TICKS);
            err_dac++;
        end
        reg_write(`AUDIO_ADR_CTRL0, 32'h0, 4'h1);
        dac_phase    = 1'b0;
        dac_count_en = 1'b0;
        fifo_m.delete();
        exp_l = dac_ones(dac_s_l, 48, DAC_TICKS);
        exp_r = dac_ones(dac_s_r, 48, DAC_TICKS);
        if (ones_l > exp_l + 1 || exp_l > ones_l + 1) begin
            $display("[ERROR] %0t: dac left ones %0d, expected %0d", $time, ones_l, exp_l);
            err_dac++;
        end
        if (ones_r > exp_r + 1 || exp_r > ones_r + 1) begin
            $display("[ERROR] %0t: dac right ones %0d, expected %0d", $time, ones_r, exp_r);
            err_dac++;
        end
        if (bclk_rises != rises_before) begin
            $display("[ERROR] %0t: bit clock toggled in dac mode", $time);
            err_i2s++;
        end

        // software reset flushes the fifo only
        reg_write(`AUDIO_ADR_FIFO_LOW, $urandom_range(1, DEPTH), 4'h1);
        for (int i = 0; i < 5; i++) begin
            reg_write(`AUDIO_ADR_RIGHT, $urandom() | 32'h8000_0000, 4'hf);
        end
        check_status();
        reg_write(`AUDIO_ADR_CTRL0, 32'h1 << CTRL_RST_BIT, 4'h1);
        expect_read(`AUDIO_ADR_CTRL0, 32'h1 << CTRL_RST_BIT, err_reg);
        reg_write(`AUDIO_ADR_CTRL0, 32'h0, 4'h1);
        expect_read(`AUDIO_ADR_FIFO_LEVEL, 32'h0, err_fifo);
        expect_read(`AUDIO_ADR_STAT0, (32'h1 << STAT_LOW_BIT) | (32'h1 << STAT_EMPTY_BIT),
                    err_fifo);
        expect_read(`AUDIO_ADR_FIFO_LOW, 32'(thr_m), err_reg);
        expect_read(`AUDIO_ADR_CTRL0, 32'h0, err_reg);

        total = err_bus + err_reg + err_fifo + err_i2s + err_dac;
        $display("error counts: bus %0d, register %0d, fifo %0d, i2s %0d, dac %0d, total %0d",
                 err_bus, err_reg, err_fifo, err_i2s, err_dac, total);
        if (total == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire
